/* dcache_macros.svh */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Bits per data word.
`define DCACHE_DATA_WIDTH 64

// Bytes per data word, one mask bit each.
`define DCACHE_MASK_WIDTH 8

// Physical byte address bits.
`define DCACHE_PADDR_WIDTH 10

// Memory depth in words.
// Must equal two to the power of the word address width.
`define DCACHE_WORDS 128

`endif

/* dcache_addr_pkg.sv */
`include "dcache_macros.svh"

package dcache_addr_pkg;

  // Full byte address.
  typedef logic [`DCACHE_PADDR_WIDTH-1:0] paddr_t;

  // Byte within a word.
  typedef logic [$clog2(`DCACHE_MASK_WIDTH)-1:0] byte_offset_t;

  // Word index, used for the memory and the bypass compare.
  typedef logic [`DCACHE_PADDR_WIDTH-$bits(byte_offset_t)-1:0] word_addr_t;

  // Drops the byte offset from a byte address.
  function automatic word_addr_t word_addr(paddr_t addr);
    paddr_t shifted;
    shifted = addr >> $bits(byte_offset_t);
    return word_addr_t'(shifted);
  endfunction

endpackage

/* dcache_wbuf_pkg.sv */
`include "dcache_macros.svh"

package dcache_wbuf_pkg;
  import dcache_addr_pkg::*;

  // One data word, as a whole or as bytes.
  typedef union packed {
    logic [`DCACHE_DATA_WIDTH-1:0]      word;
    logic [`DCACHE_MASK_WIDTH-1:0][7:0] bytes;
  } dcache_word_u;

  typedef logic [`DCACHE_MASK_WIDTH-1:0] byte_mask_t;

  // A buffered store.
  typedef struct packed {
    paddr_t       paddr;
    dcache_word_u data;
    byte_mask_t   mask;
  } wbuf_entry_t;

  // Overlays the selected bytes of over onto base.
  function automatic dcache_word_u merge_bytes(dcache_word_u base, dcache_word_u over,
                                               byte_mask_t sel);
    dcache_word_u res;
    res = base;
    for (int b = 0; b < `DCACHE_MASK_WIDTH; b++) begin
      if (sel[b]) begin
        res.bytes[b] = over.bytes[b];
      end
    end
    return res;
  endfunction

endpackage

/* dcache_wbuf_queue.sv */
`timescale 1ns/100ps

module dcache_wbuf_queue
  import dcache_wbuf_pkg::*;
(
  input  logic        clk_i,
  input  wbuf_entry_t data_i,
  input  logic        el0_en_i,
  input  logic        el1_en_i,
  input  logic        mux0_sel_i,
  input  logic        mux1_sel_i,
  output wbuf_entry_t el0_snoop_o,
  output wbuf_entry_t el1_snoop_o,
  output wbuf_entry_t data_o
);

  wbuf_entry_t el0_r;
  wbuf_entry_t el1_r;
  wbuf_entry_t el1_n;

  // Head refills from the second entry or straight from the input.
  assign el1_n = mux0_sel_i ? el0_r : data_i;

  always_ff @(posedge clk_i) begin
    if (el0_en_i) begin
      el0_r <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (el1_en_i) begin
      el1_r <= el1_n;
    end
  end

  assign el0_snoop_o = el0_r;
  assign el1_snoop_o = el1_r;

  // Empty queue passes the input through.
  assign data_o = mux1_sel_i ? el1_r : data_i;

endmodule

/* dcache_wbuf.sv */
`timescale 1ns/100ps
`include "dcache_macros.svh"

module dcache_wbuf
  import dcache_addr_pkg::*;
  import dcache_wbuf_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,

  input  logic         v_i,
  input  wbuf_entry_t  wbuf_entry_i,

  input  logic         yumi_i,
  output logic         v_o,
  output wbuf_entry_t  wbuf_entry_o,

  output logic         ready_o,
  output logic         empty_o,

  input  paddr_t       bypass_addr_i,
  input  logic         bypass_v_i,
  output dcache_word_u bypass_data_o,
  output byte_mask_t   bypass_mask_o
);

  wbuf_entry_t el0;
  wbuf_entry_t el1;

  logic [1:0] num_els_r;
  logic       push;
  logic       drain;

  logic el0_valid;
  logic el1_valid;
  logic el0_en;
  logic el1_en;
  logic mux0_sel;
  logic mux1_sel;

  // Room for a store, or the head leaves this cycle.
  assign ready_o = (num_els_r != 2'd2) | yumi_i;
  assign push    = v_i & ready_o;
  assign drain   = v_o & yumi_i;

  always_comb begin
    case (num_els_r)
      2'd0: begin
        v_o       = v_i;
        empty_o   = 1'b1;
        el0_valid = 1'b0;
        el1_valid = 1'b0;
        el0_en    = 1'b0;
        el1_en    = push & ~yumi_i;
        mux0_sel  = 1'b0;
        mux1_sel  = 1'b0;
      end
      2'd1: begin
        v_o       = 1'b1;
        empty_o   = 1'b0;
        el0_valid = 1'b0;
        el1_valid = 1'b1;
        el0_en    = push & ~yumi_i;
        el1_en    = push & yumi_i;
        mux0_sel  = 1'b0;
        mux1_sel  = 1'b1;
      end
      2'd2: begin
        v_o       = 1'b1;
        empty_o   = 1'b0;
        el0_valid = 1'b1;
        el1_valid = 1'b1;
        el0_en    = push & yumi_i;
        el1_en    = yumi_i;
        mux0_sel  = 1'b1;
        mux1_sel  = 1'b1;
      end
      default: begin
        v_o       = 1'b0;
        empty_o   = 1'b0;
        el0_valid = 1'b0;
        el1_valid = 1'b0;
        el0_en    = 1'b0;
        el1_en    = 1'b0;
        mux0_sel  = 1'b0;
        mux1_sel  = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      num_els_r <= 2'd0;
    end else begin
      num_els_r <= num_els_r + 2'(push) - 2'(drain);
    end
  end

  dcache_wbuf_queue u_queue (
    .clk_i       (clk_i),
    .data_i      (wbuf_entry_i),
    .el0_en_i    (el0_en),
    .el1_en_i    (el1_en),
    .mux0_sel_i  (mux0_sel),
    .mux1_sel_i  (mux1_sel),
    .el0_snoop_o (el0),
    .el1_snoop_o (el1),
    .data_o      (wbuf_entry_o)
  );

  word_addr_t   bypass_word;
  byte_mask_t   sel0;
  byte_mask_t   sel1;
  byte_mask_t   sel2;
  dcache_word_u el0or1_data;
  dcache_word_u bypass_data_n;
  byte_mask_t   bypass_mask_n;

  assign bypass_word = word_addr(bypass_addr_i);

  assign sel0 = {`DCACHE_MASK_WIDTH{el0_valid & (word_addr(el0.paddr) == bypass_word)}}
                & el0.mask;
  assign sel1 = {`DCACHE_MASK_WIDTH{el1_valid & (word_addr(el1.paddr) == bypass_word)}}
                & el1.mask;
  assign sel2 = {`DCACHE_MASK_WIDTH{push & (word_addr(wbuf_entry_i.paddr) == bypass_word)}}
                & wbuf_entry_i.mask;

  assign bypass_mask_n = sel0 | sel1 | sel2;

  // The input beats el0 and el0 beats the head.
  assign el0or1_data   = merge_bytes(el1.data, el0.data, sel0);
  assign bypass_data_n = merge_bytes(el0or1_data, wbuf_entry_i.data, sel2);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bypass_mask_o <= '0;
    end else if (bypass_v_i) begin
      bypass_mask_o <= bypass_mask_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bypass_v_i) begin
      bypass_data_o <= bypass_data_n;
    end
  end

  a_yumi_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o);

  a_occupancy: assert property (@(posedge clk_i) disable iff (reset_i)
    num_els_r <= 2'd2);

endmodule

/* dcache_data_mem.sv */
`timescale 1ns/100ps
`include "dcache_macros.svh"

module dcache_data_mem
  import dcache_addr_pkg::*;
  import dcache_wbuf_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,

  input  logic         wr_v_i,
  input  wbuf_entry_t  wr_entry_i,
  output logic         wr_yumi_o,

  input  logic         rd_v_i,
  input  paddr_t       rd_addr_i,

  input  dcache_word_u bypass_data_i,
  input  byte_mask_t   bypass_mask_i,

  output logic         rd_v_o,
  output dcache_word_u rd_data_o
);

  dcache_word_u mem_r [`DCACHE_WORDS];

  word_addr_t   wr_idx;
  word_addr_t   rd_idx;
  logic         rd_v_r;
  dcache_word_u rd_data_r;

  assign wr_idx = word_addr(wr_entry_i.paddr);
  assign rd_idx = word_addr(rd_addr_i);

  // Loads take the single port first.
  assign wr_yumi_o = wr_v_i & ~rd_v_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `DCACHE_WORDS; i++) begin
        mem_r[i].word <= '0;
      end
    end else if (wr_yumi_o) begin
      mem_r[wr_idx] <= merge_bytes(mem_r[wr_idx], wr_entry_i.data, wr_entry_i.mask);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_v_i) begin
      rd_data_r.word <= mem_r[rd_idx].word;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_v_r <= 1'b0;
    end else begin
      rd_v_r <= rd_v_i;
    end
  end

  assign rd_v_o = rd_v_r;

  // Buffered store bytes cover the array word.
  assign rd_data_o = merge_bytes(rd_data_r, bypass_data_i, bypass_mask_i);

endmodule

/* dcache_store_path.sv */
`timescale 1ns/100ps

module dcache_store_path
  import dcache_addr_pkg::*;
  import dcache_wbuf_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,

  input  logic         store_v_i,
  input  wbuf_entry_t  store_entry_i,
  output logic         store_ready_o,

  input  logic         load_v_i,
  input  paddr_t       load_addr_i,
  output logic         load_v_o,
  output dcache_word_u load_data_o,

  output logic         empty_o
);

  logic         wbuf_v;
  wbuf_entry_t  wbuf_entry;
  logic         wbuf_yumi;
  dcache_word_u bypass_data;
  byte_mask_t   bypass_mask;

  dcache_wbuf u_wbuf (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .v_i           (store_v_i),
    .wbuf_entry_i  (store_entry_i),
    .yumi_i        (wbuf_yumi),
    .v_o           (wbuf_v),
    .wbuf_entry_o  (wbuf_entry),
    .ready_o       (store_ready_o),
    .empty_o       (empty_o),
    .bypass_addr_i (load_addr_i),
    .bypass_v_i    (load_v_i),
    .bypass_data_o (bypass_data),
    .bypass_mask_o (bypass_mask)
  );

  // Drains the buffer head whenever no load holds the port.
  dcache_data_mem u_mem (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .wr_v_i        (wbuf_v),
    .wr_entry_i    (wbuf_entry),
    .wr_yumi_o     (wbuf_yumi),
    .rd_v_i        (load_v_i),
    .rd_addr_i     (load_addr_i),
    .bypass_data_i (bypass_data),
    .bypass_mask_i (bypass_mask),
    .rd_v_o        (load_v_o),
    .rd_data_o     (load_data_o)
  );

endmodule

/* tb_dcache_store_path.sv */
`timescale 1ns/100ps
`include "dcache_macros.svh"

module tb_dcache_store_path
  import dcache_addr_pkg::*;
  import dcache_wbuf_pkg::*;
;

  localparam int CLK_HALF    = 20;
  localparam int DRIVE_DELAY = 2;
  localparam int MEM_BYTES   = `DCACHE_WORDS * `DCACHE_MASK_WIDTH;

  logic         clk_i;
  logic         reset_i;
  logic         store_v_i;
  wbuf_entry_t  store_entry_i;
  logic         store_ready_o;
  logic         load_v_i;
  paddr_t       load_addr_i;
  logic         load_v_o;
  dcache_word_u load_data_o;
  logic         empty_o;

  integer     seed;
  int         errors;
  int         checks;
  logic       last_ready;
  logic [7:0] model_mem [MEM_BYTES];
  bit         touched [`DCACHE_WORDS];

  dcache_store_path u_dut (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .store_v_i     (store_v_i),
    .store_entry_i (store_entry_i),
    .store_ready_o (store_ready_o),
    .load_v_i      (load_v_i),
    .load_addr_i   (load_addr_i),
    .load_v_o      (load_v_o),
    .load_data_o   (load_data_o),
    .empty_o       (empty_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_HALF) clk_i = ~clk_i;
  end

  task automatic check_word(input dcache_word_u exp, input dcache_word_u got,
                            input string what);
    checks++;
    if (got.word !== exp.word) begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got.word, exp.word);
    end
  endtask

  task automatic check_flag(input string name, input bit got, input bit exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %0b, expected %0b", $time, name, got, exp);
    end
  endtask

  // Byte index is word index times bytes per word plus the offset.
  task automatic model_store(input wbuf_entry_t st);
    int w;
    w = int'(st.paddr) / `DCACHE_MASK_WIDTH;
    touched[w] = 1'b1;
    for (int b = 0; b < `DCACHE_MASK_WIDTH; b++) begin
      if (st.mask[b]) begin
        model_mem[w * `DCACHE_MASK_WIDTH + b] = st.data.bytes[b];
      end
    end
  endtask

  function automatic dcache_word_u model_word(input paddr_t a);
    dcache_word_u r;
    int w;
    w = int'(a) / `DCACHE_MASK_WIDTH;
    for (int b = 0; b < `DCACHE_MASK_WIDTH; b++) begin
      r.bytes[b] = model_mem[w * `DCACHE_MASK_WIDTH + b];
    end
    return r;
  endfunction

  // Few distinct words so that bypass hits are common.
  task automatic rand_addr(output paddr_t a);
    word_addr_t   w;
    byte_offset_t off;
    case ($unsigned($random(seed)) % 4)
      0: w = word_addr_t'(3);
      1: w = word_addr_t'(4);
      2: w = word_addr_t'(66);
      default: w = word_addr_t'(127);
    endcase
    off = byte_offset_t'($random(seed));
    a = {w, off};
  endtask

  task automatic rand_entry(output wbuf_entry_t e);
    paddr_t a;
    rand_addr(a);
    e.paddr = a;
    e.data.word = {$random(seed), $random(seed)};
    e.mask = byte_mask_t'($random(seed));
  endtask

  // One clock cycle. Called and returns a fixed delay after a rising edge.
  task automatic step(input logic st_v, input wbuf_entry_t st, input logic ld_v,
                      input paddr_t ld_addr);
    dcache_word_u exp;
    logic         accepted;
    store_v_i     = st_v;
    store_entry_i = st;
    load_v_i      = ld_v;
    load_addr_i   = ld_addr;
    #1;
    last_ready = store_ready_o;
    accepted   = st_v & store_ready_o;
    if (accepted) begin
      model_store(st);
    end
    exp = model_word(ld_addr);
    @(posedge clk_i);
    #(DRIVE_DELAY);
    store_v_i = 1'b0;
    load_v_i  = 1'b0;
    check_flag("load_v_o", load_v_o, ld_v);
    if (ld_v) begin
      check_word(exp, load_data_o, $sformatf("load_data_o at %h", ld_addr));
    end
  endtask

  task automatic idle();
    step(1'b0, '0, 1'b0, '0);
  endtask

  task automatic wait_empty(input int max_cycles);
    int n;
    n = 0;
    while (!empty_o && n < max_cycles) begin
      idle();
      n++;
    end
    if (!empty_o) begin
      $display("Timeout: write buffer still holds stores after %0d cycles", max_cycles);
      $display("*** FAILED ***");
      $finish;
    end
  endtask

  task automatic end_test(input string name, input int err_mark);
    if (errors == err_mark) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err_mark);
    end
  endtask

  initial begin
    wbuf_entry_t e;
    wbuf_entry_t e2;
    paddr_t      a;
    logic        st_v;
    logic        ld_v;
    int          err_mark;
    store_v_i     = 1'b0;
    store_entry_i = '0;
    load_v_i      = 1'b0;
    load_addr_i   = '0;
    reset_i       = 1'b1;
    seed          = 32'hfff4_5e5a;
    errors        = 0;
    checks        = 0;
    last_ready    = 1'b0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      model_mem[i] = 8'h00;
    end
    for (int i = 0; i < `DCACHE_WORDS; i++) begin
      touched[i] = 1'b0;
    end
    repeat (16) @(posedge clk_i);
    #(DRIVE_DELAY);
    reset_i = 1'b0;

    err_mark = errors;
    check_flag("empty_o", empty_o, 1'b1);
    check_flag("store_ready_o", store_ready_o, 1'b1);
    check_flag("load_v_o", load_v_o, 1'b0);
    for (int i = 0; i < 8; i++) begin
      step(1'b0, '0, 1'b1, paddr_t'($random(seed)));
    end
    end_test("after_reset", err_mark);

    // Loads held high keep the store in the buffer.
    err_mark = errors;
    e.paddr     = {word_addr_t'(2), byte_offset_t'(0)};
    e.data.word = 64'h8877_6655_4433_2211;
    e.mask      = 8'hf0;
    step(1'b1, e, 1'b1, {word_addr_t'(9), byte_offset_t'(0)});
    for (int i = 0; i < 3; i++) begin
      step(1'b0, '0, 1'b1, {word_addr_t'(2), byte_offset_t'(i)});
      check_flag("empty_o", empty_o, 1'b0);
    end
    wait_empty(8);
    end_test("buffered_bypass", err_mark);

    err_mark = errors;
    rand_entry(e);
    step(1'b1, e, 1'b1, e.paddr);
    wait_empty(8);
    e.paddr     = {word_addr_t'(5), byte_offset_t'(0)};
    e.data.word = 64'h1111_1111_1111_1111;
    e.mask      = 8'h0f;
    e2          = e;
    e2.data.word = 64'h2222_2222_2222_2222;
    e2.mask      = 8'h3c;
    step(1'b1, e, 1'b1, e.paddr);
    step(1'b1, e2, 1'b1, e2.paddr);
    e.data.word = 64'h0000_2222_2222_1111;
    check_word(e.data, load_data_o, "merged word 5");
    wait_empty(8);
    end_test("same_cycle_and_merge", err_mark);

    // Two stores fill the buffer while loads block the port.
    err_mark = errors;
    for (int i = 0; i < 3; i++) begin
      e.paddr     = {word_addr_t'(20 + i), byte_offset_t'(0)};
      e.data.word = {$random(seed), $random(seed)};
      e.mask      = 8'hff;
      step(1'b1, e, 1'b1, {word_addr_t'(30), byte_offset_t'(0)});
      check_flag("store_ready_o", last_ready, i < 2);
    end
    check_flag("empty_o", empty_o, 1'b0);
    wait_empty(10);
    for (int w = 0; w < `DCACHE_WORDS; w++) begin
      if (touched[w]) begin
        step(1'b0, '0, 1'b1, {word_addr_t'(w), byte_offset_t'(0)});
      end
    end
    end_test("back_pressure", err_mark);

    err_mark = errors;
    for (int i = 0; i < 2000; i++) begin
      rand_entry(e);
      rand_addr(a);
      st_v = ($unsigned($random(seed)) % 2) == 1;
      ld_v = ($unsigned($random(seed)) % 3) == 0;
      step(st_v, e, ld_v, a);
    end
    end_test("random_mix", err_mark);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+.
dcache_addr_pkg.sv
dcache_wbuf_pkg.sv
dcache_wbuf_queue.sv
dcache_wbuf.sv
dcache_data_mem.sv
dcache_store_path.sv
tb_dcache_store_path.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_dcache_store_path -f all.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if grep -qF '*** PASSED ***' <<< "$out"; then
  exit 0
fi
exit 1
